// File: pio_dma_tx.f
+incdir+source
+incdir+tb
source/tlp_pkg.sv
source/tx_bus_pkg.sv
source/tx_beat_if.sv
source/cpl_field_calc.sv
source/cpl_builder.sv
source/mwr_builder.sv
source/tx_arbiter.sv
source/pio_dma_tx_engine.sv
tb/tb_pio_dma_tx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the transmit engine testbench with verilator, runs it and
# decides pass or fail from the simulation log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_pio_dma_tx -f pio_dma_tx.f -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  && grep -qx "test passed" sim.log \
  && echo "simulation ok, see sim.log" \
  || { echo "simulation FAILED, see build.log and sim.log"; exit 1; }

// File: tb/tb_tlp_model.svh
/*
  expected beat model of the transmit engine
  builds the beats of each packet from the request fields,
  plus the random source and the value check of the testbench
*/
`ifndef TB_TLP_MODEL_SVH
`define TB_TLP_MODEL_SVH

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr = lfsr_step(lfsr);
    v = {v[30:0], lfsr[0]};
  end
  return v;
endfunction

// read memory contents, fixed per dw address
function automatic logic [31:0] mem_word(input logic [10:0] a);
  return {a, 10'h2A5, ~a};
endfunction

function automatic logic [63:0] byte_mask(input logic [7:0] keep);
  logic [63:0] m;
  for (int i = 0; i < 8; i++) begin
    m[i*8 +: 8] = {8{keep[i]}};
  end
  return m;
endfunction

function automatic logic [11:0] byte_count_of(input logic [9:0] len, input logic [7:0] be);
  int lo_f;
  int hi_f;
  int hi_l;
  lo_f = -1;
  hi_f = -1;
  hi_l = -1;
  for (int i = 0; i < 4; i++) begin
    if (be[i] && lo_f < 0) lo_f = i;
    if (be[i]) hi_f = i;
    if (be[i+4]) hi_l = i;
  end
  if (be[7:4] == 4'h0) begin
    return (lo_f < 0) ? 12'd1 : 12'(hi_f - lo_f + 1);  // span inside one dw
  end
  return 12'(int'(len) * 4 - lo_f - (3 - hi_l));
endfunction

function automatic logic [6:0] lower_addr_of(input logic wd, input logic [12:0] addr,
                                             input logic [3:0] fbe);
  logic [1:0] first;
  casez (fbe)
    4'b???1: first = 2'd0;
    4'b??10: first = 2'd1;
    4'b?100: first = 2'd2;
    4'b1000: first = 2'd3;
    default: first = 2'd0;
  endcase
  return wd ? {addr[6:2], first} : 7'd0;
endfunction

// entry is {kind, data, keep, last}, kind 1 for a write
function automatic void push_beat(input logic kind, input logic [63:0] data,
                                  input logic [7:0] keep, input logic last);
  exp_q.push_back({kind, data, keep, last});
endfunction

function automatic void push_cpl();
  logic [11:0] bc;
  logic [6:0]  la;
  logic [6:0]  ft;
  bc = byte_count_of(req_len, req_be);
  la = lower_addr_of(req_compl_wd, req_addr, req_be[3:0]);
  ft = req_compl_wd ? 7'h4A : 7'h0A;  // cpld or cpl
  push_beat(1'b0, {completer_id, 4'h0, bc, 1'b0, ft, 1'b0, req_tc, 4'h0,
                   req_td, req_ep, req_attr, 2'b00, req_len}, 8'hFF, 1'b0);
  push_beat(1'b0, {mem_word(req_addr[12:2]), req_rid, req_tag, 1'b0, la},
            req_compl_wd ? 8'hFF : 8'h0F, 1'b1);
endfunction

function automatic void push_mwr();
  int n;
  n = int'(dma_payload_size);
  push_beat(1'b1, {completer_id, 8'h0F, 8'hFF, 1'b0, 7'h40, 1'b0, 3'b000, 4'h0,
                   1'b0, 1'b0, 2'b00, 2'b00, dma_payload_size}, 8'hFF, 1'b0);
  push_beat(1'b1, {pay_dw[0], dma_host_addr[31:2], 2'b00}, 8'hFF, n == 1);
  for (int k = 1; k < n; k += 2) begin
    if (k + 1 < n) begin
      push_beat(1'b1, {pay_dw[k+1], pay_dw[k]}, 8'hFF, k + 2 >= n);
    end else begin
      push_beat(1'b1, {32'h0, pay_dw[k]}, 8'h0F, 1'b1);  // odd dw left over
    end
  end
endfunction

task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
  if (got !== exp) begin
    $display("mismatch %s got %h expected %h", name, got, exp);
    $display("test failed");
    $fatal(1);
  end
endtask

task automatic abort_run(input string why);
  $display("%s", why);
  $display("test failed");
  $fatal(1);
endtask

`endif

// File: tb/tb_pio_dma_tx.sv
/*
  testbench of the pio dma transmit engine
  random completions and dma writes under random back-pressure,
  each stream beat compared with an expected beat queue
*/
`default_nettype none

`include "pio_dma_tx_cfg.svh"

module tb_pio_dma_tx;

  localparam int NUM_TXN    = 200;
  localparam int WAIT_LIMIT = 2000;  // cycles per transaction

  logic                   clk;
  logic                   rst_n;
  logic                   s_axis_tx_tready;
  logic [`DATA_W-1:0]     s_axis_tx_tdata;
  logic [`KEEP_W-1:0]     s_axis_tx_tkeep;
  logic                   s_axis_tx_tlast;
  logic                   s_axis_tx_tvalid;
  logic                   req_compl;
  logic                   req_compl_wd;
  logic                   compl_done;
  logic [2:0]             req_tc;
  logic                   req_td;
  logic                   req_ep;
  logic [1:0]             req_attr;
  logic [`LEN_W-1:0]      req_len;
  logic [15:0]            req_rid;
  logic [7:0]             req_tag;
  logic [7:0]             req_be;
  logic [`REQ_ADDR_W-1:0] req_addr;
  logic [`RD_ADDR_W-1:0]  rd_addr;
  logic [3:0]             rd_be;
  logic [31:0]            rd_data;
  logic [15:0]            completer_id;
  logic [63:0]            dma_data;
  logic [31:0]            dma_host_addr;
  logic                   dma_start_wr;
  logic [`LEN_W-1:0]      dma_payload_size;
  logic                   dma_data_taken;
  logic                   dma_wr_done;

  logic [31:0] lfsr;
  logic [31:0] pay_dw [0:33];   // payload of the current write
  logic [73:0] exp_q [$];
  int          taken_total;
  int          qw_base;         // taken_total at write start
  int          cpl_done_cnt;
  int          mwr_done_cnt;
  int          cpl_target;
  int          mwr_target;
  logic        cpl_due;
  logic        mwr_due;
  logic        stalled;
  logic [`RD_ADDR_W-1:0] exp_rd_addr;  // read port of the captured request
  logic [3:0]            exp_rd_be;
  logic                  rd_live;

  `include "tb_tlp_model.svh"

  pio_dma_tx_engine dut (.*);

  always #50 clk = ~clk;

  // check the stream at the rising edge, drive inputs at the falling edge
  task automatic step_clock();
    logic [73:0] e;
    int          q;
    @(posedge clk);
    if (rst_n) begin
      check_val("compl_done", 64'(compl_done), 64'(cpl_due));
      check_val("dma_wr_done", 64'(dma_wr_done), 64'(mwr_due));
      if (rd_live) begin
        check_val("rd_addr", 64'(rd_addr), 64'(exp_rd_addr));
        check_val("rd_be", 64'(rd_be), 64'(exp_rd_be));
      end
      if (req_compl) begin
        exp_rd_addr = req_addr[12:2];  // valid from the next cycle on
        exp_rd_be   = req_be[3:0];
        rd_live     = 1'b1;
      end
      if (compl_done) cpl_done_cnt++;
      if (dma_wr_done) mwr_done_cnt++;
      if (dma_data_taken) taken_total++;
      if (stalled) check_val("s_axis_tx_tvalid", 64'(s_axis_tx_tvalid), 64'd1);
      cpl_due = 1'b0;
      mwr_due = 1'b0;
      stalled = s_axis_tx_tvalid && !s_axis_tx_tready;
      if (s_axis_tx_tvalid) begin
        if (exp_q.size() == 0) abort_run("beat sent while no packet was outstanding");
        e = exp_q[0];
        check_val("s_axis_tx_tdata", s_axis_tx_tdata & byte_mask(e[8:1]),
                  e[72:9] & byte_mask(e[8:1]));
        check_val("s_axis_tx_tkeep", 64'(s_axis_tx_tkeep), 64'(e[8:1]));
        check_val("s_axis_tx_tlast", 64'(s_axis_tx_tlast), 64'(e[0]));
        if (s_axis_tx_tready) begin
          void'(exp_q.pop_front());
          mwr_due = e[0] && e[73];  // done expected next cycle
          cpl_due = e[0] && !e[73];
        end
      end
    end
    @(negedge clk);
    q = taken_total - qw_base;
    if (q > 16) q = 16;
    s_axis_tx_tready = (rand_bits(2) != 32'd0);  // ready three cycles in four
    rd_data          = mem_word(rd_addr);
    dma_data         = {pay_dw[2*q+1], pay_dw[2*q]};
    req_compl        = 1'b0;
    dma_start_wr     = 1'b0;
  endtask

  task automatic issue_cpl();
    logic [3:0] fbe;
    logic [3:0] lbe;
    fbe          = 4'(rand_bits(4));
    req_compl_wd = 1'(rand_bits(1));
    req_tc       = 3'(rand_bits(3));
    req_td       = 1'(rand_bits(1));
    req_ep       = 1'(rand_bits(1));
    req_attr     = 2'(rand_bits(2));
    req_rid      = 16'(rand_bits(16));
    req_tag      = 8'(rand_bits(8));
    req_addr     = 13'(rand_bits(13));
    if (rand_bits(1) != 32'd0) begin
      req_len = 10'd1;  // single dw, first enables may be zero
      lbe     = 4'h0;
    end else begin
      req_len = 10'(2 + rand_bits(7));
      lbe     = 4'(rand_bits(4));
      if (fbe == 4'h0) fbe = 4'h1;
      if (lbe == 4'h0) lbe = 4'h8;
    end
    req_be    = {lbe, fbe};
    req_compl = 1'b1;
    cpl_target++;
    push_cpl();
  endtask

  task automatic issue_mwr();
    dma_payload_size = 10'(1 + rand_bits(5));
    dma_host_addr    = rand_bits(32);
    for (int k = 0; k < 34; k++) begin
      pay_dw[k] = rand_bits(32);
    end
    qw_base      = taken_total;
    dma_data     = {pay_dw[1], pay_dw[0]};
    dma_start_wr = 1'b1;
    mwr_target++;
    push_mwr();
  endtask

  initial begin : main
    int mode;
    int n_wait;
    clk = 1'b0;
    rst_n = 1'b0;
    lfsr = 32'h8885;
    s_axis_tx_tready = 1'b0;
    req_compl = 1'b0;
    req_compl_wd = 1'b0;
    req_tc = '0;
    req_td = 1'b0;
    req_ep = 1'b0;
    req_attr = '0;
    req_len = '0;
    req_rid = '0;
    req_tag = '0;
    req_be = '0;
    req_addr = '0;
    rd_data = '0;
    dma_data = '0;
    dma_host_addr = '0;
    dma_start_wr = 1'b0;
    dma_payload_size = '0;
    for (int k = 0; k < 34; k++) begin
      pay_dw[k] = '0;
    end
    {taken_total, qw_base, cpl_done_cnt, mwr_done_cnt, cpl_target, mwr_target} = '0;
    {cpl_due, mwr_due, stalled} = '0;
    exp_rd_addr = '0;
    exp_rd_be = '0;
    rd_live = 1'b0;
    completer_id = 16'(rand_bits(16));

    repeat (8) step_clock();
    check_val("s_axis_tx_tvalid", 64'(s_axis_tx_tvalid), 64'd0);
    check_val("s_axis_tx_tlast", 64'(s_axis_tx_tlast), 64'd0);
    check_val("compl_done", 64'(compl_done), 64'd0);
    check_val("dma_wr_done", 64'(dma_wr_done), 64'd0);
    check_val("dma_data_taken", 64'(dma_data_taken), 64'd0);
    rst_n = 1'b1;

    for (int t = 0; t < NUM_TXN; t++) begin
      // 0 completion, 1 write, 2 both at once, 3 write then completion
      mode = int'(rand_bits(2));
      if (mode == 0 || mode == 2) issue_cpl();
      if (mode != 0) issue_mwr();
      if (mode == 3) begin
        repeat (1 + rand_bits(1)) step_clock();
        issue_cpl();
      end
      n_wait = 0;
      while (cpl_done_cnt < cpl_target || mwr_done_cnt < mwr_target) begin
        step_clock();
        n_wait++;
        if (n_wait > WAIT_LIMIT) abort_run("timeout waiting for a packet to complete");
      end
      if (mode != 0) begin
        check_val("dma_data_taken pulses", 64'(taken_total - qw_base),
                  64'((int'(dma_payload_size) + 1) / 2));
      end
    end

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/pio_dma_tx_engine.sv
/*
  pio dma transmit engine
  completion and dma write builders sharing the 64-bit
  transmit stream through a packet arbiter
*/
`default_nettype none

`include "pio_dma_tx_cfg.svh"

module pio_dma_tx_engine (
  input  wire                   clk,
  input  wire                   rst_n,

  input  wire                   s_axis_tx_tready,
  output logic [`DATA_W-1:0]    s_axis_tx_tdata,
  output logic [`KEEP_W-1:0]    s_axis_tx_tkeep,
  output logic                  s_axis_tx_tlast,
  output logic                  s_axis_tx_tvalid,

  input  wire                   req_compl,
  input  wire                   req_compl_wd,
  output logic                  compl_done,
  input  wire [2:0]             req_tc,
  input  wire                   req_td,
  input  wire                   req_ep,
  input  wire [1:0]             req_attr,
  input  wire [`LEN_W-1:0]      req_len,
  input  wire [15:0]            req_rid,
  input  wire [7:0]             req_tag,
  input  wire [7:0]             req_be,
  input  wire [`REQ_ADDR_W-1:0] req_addr,
  output logic [`RD_ADDR_W-1:0] rd_addr,   // to read memory
  output logic [3:0]            rd_be,
  input  wire [31:0]            rd_data,
  input  wire [15:0]            completer_id,

  input  wire [63:0]            dma_data,
  input  wire [31:0]            dma_host_addr,
  input  wire                   dma_start_wr,
  input  wire [`LEN_W-1:0]      dma_payload_size,
  output logic                  dma_data_taken,
  output logic                  dma_wr_done
);

  tx_beat_if cpl_if ();
  tx_beat_if mwr_if ();

  cpl_builder u_cpl_builder (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_compl    (req_compl),
    .req_compl_wd (req_compl_wd),
    .req_tc       (req_tc),
    .req_td       (req_td),
    .req_ep       (req_ep),
    .req_attr     (req_attr),
    .req_len      (req_len),
    .req_rid      (req_rid),
    .req_tag      (req_tag),
    .req_be       (req_be),
    .req_addr     (req_addr),
    .completer_id (completer_id),
    .rd_data      (rd_data),
    .rd_addr      (rd_addr),
    .rd_be        (rd_be),
    .compl_done   (compl_done),
    .bus          (cpl_if.builder)
  );

  mwr_builder u_mwr_builder (
    .clk              (clk),
    .rst_n            (rst_n),
    .completer_id     (completer_id),
    .dma_start_wr     (dma_start_wr),
    .dma_host_addr    (dma_host_addr),
    .dma_payload_size (dma_payload_size),
    .dma_data         (dma_data),
    .dma_data_taken   (dma_data_taken),
    .dma_wr_done      (dma_wr_done),
    .bus              (mwr_if.builder)
  );

  tx_arbiter u_tx_arbiter (
    .clk     (clk),
    .rst_n   (rst_n),
    .tready  (s_axis_tx_tready),
    .tdata   (s_axis_tx_tdata),
    .tkeep   (s_axis_tx_tkeep),
    .tlast   (s_axis_tx_tlast),
    .tvalid  (s_axis_tx_tvalid),
    .cpl_bus (cpl_if.arbiter),
    .mwr_bus (mwr_if.arbiter)
  );

endmodule

`default_nettype wire

// File: source/tx_arbiter.sv
/*
  transmit arbiter
  grants the stream to one builder for a whole packet,
  completions first, and muxes the granted beat out
*/
`default_nettype none

`include "pio_dma_tx_cfg.svh"

module tx_arbiter (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                tready,
  output logic [`DATA_W-1:0] tdata,
  output logic [`KEEP_W-1:0] tkeep,
  output logic               tlast,
  output logic               tvalid,
  tx_beat_if.arbiter         cpl_bus,
  tx_beat_if.arbiter         mwr_bus
);
  import tx_bus_pkg::*;

  typedef enum logic [1:0] {OWN_NONE, OWN_CPL, OWN_MWR} owner_e;

  owner_e   owner;
  logic     grant_cpl;
  logic     grant_mwr;
  tx_beat_t sel_beat;

  // idle grant is combinational so a pending builder starts the same cycle
  assign grant_cpl = (owner == OWN_CPL) || (owner == OWN_NONE && cpl_bus.pkt_pending);
  assign grant_mwr = (owner == OWN_MWR) ||
                     (owner == OWN_NONE && !cpl_bus.pkt_pending && mwr_bus.pkt_pending);

  assign cpl_bus.grant = grant_cpl;
  assign mwr_bus.grant = grant_mwr;
  assign cpl_bus.ready = grant_cpl && tready;
  assign mwr_bus.ready = grant_mwr && tready;

  assign sel_beat = grant_mwr ? mwr_bus.beat : cpl_bus.beat;
  assign tvalid   = (grant_cpl && cpl_bus.valid) || (grant_mwr && mwr_bus.valid);
  assign tdata    = sel_beat.data;
  assign tkeep    = sel_beat.keep;
  assign tlast    = tvalid && sel_beat.last;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      owner <= OWN_NONE;
    end else if (tvalid && tready && tlast) begin
      owner <= OWN_NONE;  // packet done, rearbitrate
    end else if (grant_cpl) begin
      owner <= OWN_CPL;
    end else if (grant_mwr) begin
      owner <= OWN_MWR;
    end
  end

  grant_chk: assert property (@(posedge clk) disable iff (!rst_n)
    !(cpl_bus.valid && !cpl_bus.grant) && !(mwr_bus.valid && !mwr_bus.grant))
    else $error("builder drove valid without grant");

  // stalled beat must stay on the stream untouched
  hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
    (tvalid && !tready) |=> (tvalid && $stable(tdata) && $stable(tkeep) && $stable(tlast)))
    else $error("stream beat changed while stalled");

endmodule

`default_nettype wire

// File: source/mwr_builder.sv
/*
  dma memory write builder
  sends header, address beat and payload of a 32-bit address
  memory write, pulling one quadword per dma_data_taken
*/
`default_nettype none

`include "pio_dma_tx_cfg.svh"

module mwr_builder (
  input  wire              clk,
  input  wire              rst_n,
  input  wire [15:0]       completer_id,
  input  wire              dma_start_wr,
  input  wire [31:0]       dma_host_addr,
  input  wire [`LEN_W-1:0] dma_payload_size,
  input  wire [63:0]       dma_data,
  output logic             dma_data_taken,
  output logic             dma_wr_done,
  tx_beat_if.builder       bus
);
  import tlp_pkg::*;
  import tx_bus_pkg::*;

  typedef enum logic [1:0] {MW_IDLE, MW_HDR, MW_ADDR, MW_DATA} mw_state_e;

  mw_state_e         state;
  logic [`LEN_W-1:0] len_q;
  logic [`LEN_W-1:0] rem;     // dw still to place after dw0
  logic [29:0]       addr_q;
  logic [31:0]       hi_q;    // upper dw of previous quadword
  logic              xfer;
  tx_beat_t          beat;

  always_comb begin
    beat = '0;
    case (state)
      MW_HDR: begin
        beat.data = {completer_id, `MWR_TAG, 4'hF, 4'hF,   // last be, first be
                     1'b0, FT_MWR, 1'b0, 3'b000, 4'b0000,
                     1'b0, 1'b0, 2'b00, 2'b00, len_q};     // td, ep, attr zero
        beat.keep = KEEP_ALL;
      end
      MW_ADDR: begin
        beat.data = {dma_data[31:0], addr_q, 2'b00};
        beat.keep = KEEP_ALL;
        beat.last = (len_q == `LEN_W'(1));
      end
      MW_DATA: begin
        beat.data = {(rem == `LEN_W'(1)) ? 32'h0 : dma_data[31:0], hi_q};
        beat.keep = (rem == `LEN_W'(1)) ? KEEP_LO : KEEP_ALL;
        beat.last = (rem <= `LEN_W'(2));
      end
      default: beat = '0;
    endcase
  end

  assign xfer = bus.valid && bus.ready;

  // a fresh quadword goes out with every beat except an even-length tail
  assign dma_data_taken = xfer && (state == MW_ADDR ||
                                   (state == MW_DATA && rem != `LEN_W'(1)));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= MW_IDLE;
      dma_wr_done <= 1'b0;
    end else begin
      dma_wr_done <= xfer && beat.last;
      case (state)
        MW_IDLE: if (dma_start_wr) state <= MW_HDR;
        MW_HDR:  if (xfer) state <= MW_ADDR;
        MW_ADDR: if (xfer) state <= beat.last ? MW_IDLE : MW_DATA;
        MW_DATA: if (xfer && beat.last) state <= MW_IDLE;
        default: state <= MW_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == MW_IDLE && dma_start_wr) begin
      len_q  <= dma_payload_size;
      addr_q <= dma_host_addr[31:2];
    end
    if (dma_data_taken) hi_q <= dma_data[63:32];
    if (xfer && state == MW_ADDR) begin
      rem <= len_q - `LEN_W'(1);
    end else if (xfer && state == MW_DATA) begin
      rem <= rem - `LEN_W'(2);
    end
  end

  assign bus.beat        = beat;
  assign bus.valid       = (state != MW_IDLE) && bus.grant;
  assign bus.pkt_pending = (state != MW_IDLE);

  size_chk: assert property (@(posedge clk) disable iff (!rst_n)
    (state == MW_IDLE && dma_start_wr) |-> dma_payload_size != '0)
    else $error("dma write started with zero payload size");

endmodule

`default_nettype wire

// File: source/cpl_builder.sv
/*
  completion builder
  captures a read request, presents it to the read memory and
  sends a two beat completion with or without one data dw
*/
`default_nettype none

`include "pio_dma_tx_cfg.svh"

module cpl_builder (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   req_compl,
  input  wire                   req_compl_wd,
  input  wire [2:0]             req_tc,
  input  wire                   req_td,
  input  wire                   req_ep,
  input  wire [1:0]             req_attr,
  input  wire [`LEN_W-1:0]      req_len,
  input  wire [15:0]            req_rid,
  input  wire [7:0]             req_tag,
  input  wire [7:0]             req_be,
  input  wire [`REQ_ADDR_W-1:0] req_addr,
  input  wire [15:0]            completer_id,
  input  wire [31:0]            rd_data,
  output logic [`RD_ADDR_W-1:0] rd_addr,
  output logic [3:0]            rd_be,
  output logic                  compl_done,
  tx_beat_if.builder            bus
);
  import tlp_pkg::*;
  import tx_bus_pkg::*;

  cpl_req_t    req_q;
  logic        busy;
  logic        beat_sel;  // 0 header, 1 data beat
  logic        xfer;
  logic [11:0] byte_count;
  logic [6:0]  lower_addr;
  fmt_type_e   fmt;
  tx_beat_t    beat;

  cpl_field_calc u_field_calc (
    .req        (req_q),
    .byte_count (byte_count),
    .lower_addr (lower_addr)
  );

  always_ff @(posedge clk) begin
    if (req_compl) begin
      req_q <= '{tc: req_tc, td: req_td, ep: req_ep, attr: req_attr,
                 len: req_len, rid: req_rid, tag: req_tag, be: req_be,
                 addr: req_addr, with_data: req_compl_wd};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      beat_sel   <= 1'b0;
      compl_done <= 1'b0;
    end else begin
      compl_done <= xfer && beat_sel;
      if (req_compl) begin
        busy <= 1'b1;
      end else if (xfer && beat_sel) begin
        busy <= 1'b0;
      end
      if (xfer) beat_sel <= !beat_sel;
    end
  end

  assign rd_addr = req_q.addr[`REQ_ADDR_W-1:2];
  assign rd_be   = req_q.be[3:0];
  assign fmt     = req_q.with_data ? FT_CPLD : FT_CPL;
  assign xfer    = bus.valid && bus.ready;

  always_comb begin
    if (!beat_sel) begin
      beat.data = {completer_id, 3'b000, 1'b0, byte_count,   // status 0, bcm 0
                   1'b0, fmt, 1'b0, req_q.tc, 4'b0000,
                   req_q.td, req_q.ep, req_q.attr, 2'b00, req_q.len};
      beat.keep = KEEP_ALL;
      beat.last = 1'b0;
    end else begin
      beat.data = {rd_data, req_q.rid, req_q.tag, 1'b0, lower_addr};
      beat.keep = req_q.with_data ? KEEP_ALL : KEEP_LO;  // mask data dw
      beat.last = 1'b1;
    end
  end

  assign bus.beat        = beat;
  assign bus.valid       = busy && bus.grant;
  assign bus.pkt_pending = busy;

  // rd_data is held for the pending completion, a second request would lose it
  busy_req_chk: assert property (@(posedge clk) disable iff (!rst_n)
    req_compl |-> !busy)
    else $error("completion request while previous completion outstanding");

endmodule

`default_nettype wire

// File: source/cpl_field_calc.sv
/*
  completion field calculation
  byte count and lower address from the byte enables, length
  and address of a captured read request
*/
`default_nettype none

module cpl_field_calc (
  input  wire tlp_pkg::cpl_req_t req,
  output logic [11:0]            byte_count,
  output logic [6:0]             lower_addr
);

  logic [3:0] fbe;
  logic [3:0] lbe;

  // index of the lowest set enable, 0 when none set
  function automatic logic [1:0] low_idx(input logic [3:0] be);
    logic [1:0] idx;
    idx = 2'd0;
    for (int i = 3; i >= 0; i--) begin
      if (be[i]) idx = 2'(i);
    end
    return idx;
  endfunction

  // index of the highest set enable
  function automatic logic [1:0] high_idx(input logic [3:0] be);
    logic [1:0] idx;
    idx = 2'd0;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) idx = 2'(i);
    end
    return idx;
  endfunction

  assign fbe = req.be[3:0];
  assign lbe = req.be[7:4];

  always_comb begin
    if (lbe == 4'h0) begin
      // single dw request
      if (fbe == 4'h0) begin
        byte_count = 12'd1;
      end else begin
        byte_count = 12'(high_idx(fbe) - low_idx(fbe)) + 12'd1;
      end
    end else begin
      byte_count = {req.len, 2'b00}
                 - 12'(low_idx(fbe))                 // skipped bytes in first dw
                 - 12'(2'd3 - high_idx(lbe));        // skipped bytes in last dw
    end
  end

  assign lower_addr = req.with_data ? {req.addr[6:2], low_idx(fbe)} : 7'd0;

endmodule

`default_nettype wire

// File: source/tx_beat_if.sv
/*
  builder to arbiter beat channel
  the builder offers beats only while granted, the arbiter
  passes the stream ready back to the granted side
*/
`default_nettype none

interface tx_beat_if;
  import tx_bus_pkg::*;

  tx_beat_t beat;
  logic     valid;
  logic     ready;
  logic     grant;
  logic     pkt_pending;  // packet waiting or in flight

  modport builder (
    output beat,
    output valid,
    output pkt_pending,
    input  ready,
    input  grant
  );

  modport arbiter (
    input  beat,
    input  valid,
    input  pkt_pending,
    output ready,
    output grant
  );

endinterface

`default_nettype wire

// File: source/tx_bus_pkg.sv
/*
  outgoing stream package
  one beat of the 64-bit transmit stream and its keep patterns
*/
`default_nettype none

`include "pio_dma_tx_cfg.svh"

package tx_bus_pkg;

  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic [`KEEP_W-1:0] keep;
    logic               last;
  } tx_beat_t;

  localparam logic [`KEEP_W-1:0] KEEP_ALL = 8'hFF;
  localparam logic [`KEEP_W-1:0] KEEP_LO  = 8'h0F;  // lower dw only

endpackage

`default_nettype wire

// File: source/tlp_pkg.sv
/*
  tlp package
  format/type codes of the transmitted packets and the
  completion request as captured from the receive side
*/
`default_nettype none

`include "pio_dma_tx_cfg.svh"

package tlp_pkg;

  // {fmt[1:0], type[4:0]}
  typedef enum logic [6:0] {
    FT_CPLD = 7'b10_01010,  // completion with data
    FT_CPL  = 7'b00_01010,  // completion without data
    FT_MWR  = 7'b10_00000   // 32-bit address memory write
  } fmt_type_e;

  typedef struct packed {
    logic [2:0]             tc;
    logic                   td;
    logic                   ep;
    logic [1:0]             attr;
    logic [`LEN_W-1:0]      len;
    logic [15:0]            rid;
    logic [7:0]             tag;
    logic [7:0]             be;         // {last be, first be}
    logic [`REQ_ADDR_W-1:0] addr;
    logic                   with_data;
  } cpl_req_t;

endpackage

`default_nettype wire

// File: source/pio_dma_tx_cfg.svh
/*
  pio dma tx engine configuration
  stream widths and packet field widths shared by the design
*/
`ifndef PIO_DMA_TX_CFG_SVH
`define PIO_DMA_TX_CFG_SVH

`define DATA_W      64     // stream width towards the core
`define KEEP_W      8      // one enable per byte
`define REQ_ADDR_W  13     // byte address of a captured read
`define RD_ADDR_W   11     // dw address into read memory
`define LEN_W       10     // packet length in dw

// tag carried by every dma memory write
`define MWR_TAG     8'h0F

`endif
